// File: verilog.f
design/stk_pkg.sv
design/stk_ram.sv
design/stk_seq.sv
design/stk_mask_ctr.sv
design/stk_regs.sv
design/stk_top.sv
tb/stk_assert.sv
tb/stk_tb.sv

// File: run.sh
#!/bin/sh
# build the simulation with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module stk_tb -f verilog.f -o stk_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/stk_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: tb/stk_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table-driven testbench for the register file and stack engine
// keeps its own register and stack model to build expected values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_tb;

    localparam int AW = 8;

    // row operations
    localparam logic [2:0] OP_LD     = 3'd0;
    localparam logic [2:0] OP_LDR    = 3'd1;
    localparam logic [2:0] OP_PUSH   = 3'd2;
    localparam logic [2:0] OP_PULL   = 3'd3;
    localparam logic [2:0] OP_BOTH   = 3'd4;
    localparam logic [2:0] OP_CHK    = 3'd5;
    localparam logic [2:0] OP_CHKV   = 3'd6;
    localparam logic [2:0] OP_CHKALL = 3'd7;

    typedef struct packed {
        logic [2:0]         op;
        stk_pkg::reg_sel_t  sel;
        stk_pkg::reg_mask_t mask;
        logic               uu;
        logic               poke;
        stk_pkg::word_t     data;
        stk_pkg::word_t     exp;
    } row_t;

    logic               clk;
    logic               rst;
    logic               load;
    stk_pkg::reg_sel_t  load_sel;
    stk_pkg::word_t     load_data;
    logic               push;
    logic               pull;
    logic               use_u;
    stk_pkg::reg_mask_t mask;
    stk_pkg::reg_sel_t  rd_sel;
    stk_pkg::word_t     rd_data;
    logic               busy;
    logic               done;

    integer             seed;
    row_t               rows[$];
    stk_pkg::word_t     mreg [0:8];
    stk_pkg::byte_t     mmem [0:(1 << AW) - 1];

    stk_top #(
        .STK_AW (AW)
    ) u_stk_top (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_sel  (load_sel),
        .load_data (load_data),
        .push      (push),
        .pull      (pull),
        .use_u     (use_u),
        .mask      (mask),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic add_row(input logic [2:0] op, input stk_pkg::reg_sel_t sel,
                           input stk_pkg::reg_mask_t m, input logic uu, input logic poke,
                           input stk_pkg::word_t data, input stk_pkg::word_t exp);
        rows.push_back({op, sel, m, uu, poke, data, exp});
    endtask

    // one byte per byte register, two per word register
    function automatic logic [15:0] byte_count(input stk_pkg::reg_mask_t m);
        logic [15:0] n;
        n = 16'd0;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                n = n + ((i >= 4) ? 16'd2 : 16'd1);
            end
        end
        return n;
    endfunction

    function automatic stk_pkg::reg_sel_t bit_reg(input int i, input logic uu);
        case (i)
            0:       return stk_pkg::REG_CC;
            1:       return stk_pkg::REG_A;
            2:       return stk_pkg::REG_B;
            3:       return stk_pkg::REG_DP;
            4:       return stk_pkg::REG_X;
            5:       return stk_pkg::REG_Y;
            6:       return uu ? stk_pkg::REG_S : stk_pkg::REG_U;
            default: return stk_pkg::REG_PC;
        endcase
    endfunction

    function automatic stk_pkg::word_t reg_value(input stk_pkg::reg_sel_t sel);
        return (sel <= stk_pkg::REG_PC) ? mreg[sel] : 16'h0000;
    endfunction

    // high mask bit first, low byte stored before high byte
    task automatic stack_save(input stk_pkg::reg_mask_t m, input logic uu);
        stk_pkg::reg_sel_t act;
        stk_pkg::word_t    ptr;
        stk_pkg::word_t    v;
        act = uu ? stk_pkg::REG_U : stk_pkg::REG_S;
        ptr = mreg[act];
        for (int i = 7; i >= 0; i--) begin
            if (m[i]) begin
                v = mreg[bit_reg(i, uu)];
                ptr = ptr - 16'd1;
                mmem[ptr[AW-1:0]] = v[7:0];
                if (i >= 4) begin
                    ptr = ptr - 16'd1;
                    mmem[ptr[AW-1:0]] = v[15:8];
                end
            end
        end
        mreg[act] = ptr;
    endtask

    task automatic stack_restore(input stk_pkg::reg_mask_t m, input logic uu);
        stk_pkg::reg_sel_t act;
        stk_pkg::word_t    ptr;
        stk_pkg::word_t    v;
        act = uu ? stk_pkg::REG_U : stk_pkg::REG_S;
        ptr = mreg[act];
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                v = 16'h0000;
                if (i >= 4) begin
                    v[15:8] = mmem[ptr[AW-1:0]];
                    ptr = ptr + 16'd1;
                end
                v[7:0] = mmem[ptr[AW-1:0]];
                ptr = ptr + 16'd1;
                mreg[bit_reg(i, uu)] = v;
            end
        end
        mreg[act] = ptr;
    endtask

    task automatic load_reg(input stk_pkg::reg_sel_t sel, input stk_pkg::word_t d);
        @(posedge clk);
        load      <= 1'b1;
        load_sel  <= sel;
        load_data <= d;
        @(posedge clk);
        load <= 1'b0;
        if (sel <= stk_pkg::REG_PC) begin
            mreg[sel] = (sel < stk_pkg::REG_X) ? {8'h00, d[7:0]} : d;
        end
    endtask

    task automatic read_check(input stk_pkg::reg_sel_t sel, input stk_pkg::word_t exp);
        @(posedge clk);
        rd_sel <= sel;
        @(negedge clk);
        check($sformatf("rd_data[%0d]", sel), rd_data, exp);
    endtask

    task automatic run_transfer(input logic is_push, input logic both,
                                input stk_pkg::reg_mask_t m, input logic uu, input logic poke);
        logic [15:0] n;
        logic [15:0] edges;
        n = byte_count(m);
        @(posedge clk);
        push  <= is_push;
        pull  <= !is_push || both;
        mask  <= m;
        use_u <= uu;
        // strobe is taken at the next edge
        @(posedge clk);
        push <= 1'b0;
        pull <= 1'b0;
        if (poke) begin
            // these land while busy and must be dropped
            load      <= 1'b1;
            load_sel  <= stk_pkg::REG_A;
            load_data <= ~reg_value(stk_pkg::REG_A);
            pull      <= 1'b1;
        end
        edges = 16'd1;
        @(negedge clk);
        if (n != 16'd0) begin
            check("busy", {15'h0, busy}, 16'h0001);
        end
        while (!done) begin
            if (edges > 16'd40) begin
                $display("timeout: no done within 40 cycles for mask %h", m);
                $display("Test FAILED");
                $fatal(1, "transfer never finished");
            end
            @(posedge clk);
            load  <= 1'b0;
            pull  <= 1'b0;
            edges = edges + 16'd1;
            @(negedge clk);
        end
        check("done_cycles", edges, n + 16'd1);
        check("busy", {15'h0, busy}, 16'h0000);
        check("byte_cnt", {8'h00, u_stk_top.byte_cnt}, n);
        if (is_push) begin
            stack_save(m, uu);
        end else begin
            stack_restore(m, uu);
        end
    endtask

    initial begin
        row_t              r;
        logic [31:0]       rnd;
        stk_pkg::word_t    cc_efi;
        stk_pkg::reg_sel_t c;
        clk       = 1'b0;
        rst       = 1'b1;
        load      = 1'b0;
        load_sel  = '0;
        load_data = '0;
        push      = 1'b0;
        pull      = 1'b0;
        use_u     = 1'b0;
        mask      = '0;
        rd_sel    = '0;
        seed      = 68742;
        cc_efi    = 16'((1 << stk_pkg::CC_E) | (1 << stk_pkg::CC_F) | (1 << stk_pkg::CC_I));
        for (int i = 0; i < 9; i++) begin
            mreg[i] = 16'h0000;
        end

        // load and readback, unused codes
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        for (int i = 0; i < 9; i++) begin
            add_row(OP_LDR, 4'(i), 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        end
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_LD, 4'd12, 8'h00, 1'b0, 1'b0, 16'hbeef, 16'h0000);
        add_row(OP_CHKV, 4'd9, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, 4'd15, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);

        // full push, corrupt, pull back
        add_row(OP_LD, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0080, 16'h0000);
        add_row(OP_LD, stk_pkg::REG_U, 8'h00, 1'b0, 1'b0, 16'h00f0, 16'h0000);
        add_row(OP_PUSH, 4'h0, 8'hff, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0074);
        for (int i = 0; i < 9; i++) begin
            if (i != 7) begin
                add_row(OP_LDR, 4'(i), 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
            end
        end
        add_row(OP_PULL, 4'h0, 8'hff, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0080);

        // partial mask a, b, x, y is six bytes
        add_row(OP_PUSH, 4'h0, 8'h36, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h007a);
        add_row(OP_LDR, stk_pkg::REG_X, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_LDR, stk_pkg::REG_A, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h36, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0080);
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);

        // s saved on the u stack
        add_row(OP_PUSH, 4'h0, 8'h40, 1'b1, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_U, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h00ee);
        add_row(OP_LD, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0055, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h40, 1'b1, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0080);
        add_row(OP_CHKV, stk_pkg::REG_U, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h00f0);

        // timing, empty masks, pokes while busy, push wins over pull
        add_row(OP_PUSH, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h00, 1'b1, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PUSH, 4'h0, 8'h02, 1'b0, 1'b1, 16'h0000, 16'h0000);
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_BOTH, 4'h0, 8'h90, 1'b0, 1'b1, 16'h0000, 16'h0000);
        add_row(OP_CHK, stk_pkg::REG_A, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h007b);
        add_row(OP_LDR, stk_pkg::REG_X, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_LDR, stk_pkg::REG_PC, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h90, 1'b0, 1'b1, 16'h0000, 16'h0000);
        add_row(OP_CHK, stk_pkg::REG_A, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h02, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKALL, 4'h0, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);

        // cc and pc come back from an earlier push
        add_row(OP_LD, stk_pkg::REG_CC, 8'h00, 1'b0, 1'b0, cc_efi, 16'h0000);
        add_row(OP_LDR, stk_pkg::REG_PC, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PUSH, 4'h0, 8'h81, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PUSH, 4'h0, 8'h06, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_LDR, stk_pkg::REG_CC, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_LDR, stk_pkg::REG_PC, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h06, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_PULL, 4'h0, 8'h81, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_CC, 8'h00, 1'b0, 1'b0, 16'h0000, cc_efi);
        add_row(OP_CHK, stk_pkg::REG_PC, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0000);
        add_row(OP_CHKV, stk_pkg::REG_S, 8'h00, 1'b0, 1'b0, 16'h0000, 16'h0080);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        foreach (rows[k]) begin
            r = rows[k];
            case (r.op)
                OP_LD: load_reg(r.sel, r.data);
                OP_LDR: begin
                    rnd = $random(seed);
                    load_reg(r.sel, rnd[15:0]);
                end
                OP_PUSH: run_transfer(1'b1, 1'b0, r.mask, r.uu, r.poke);
                OP_BOTH: run_transfer(1'b1, 1'b1, r.mask, r.uu, r.poke);
                OP_PULL: run_transfer(1'b0, 1'b0, r.mask, r.uu, r.poke);
                OP_CHK: read_check(r.sel, reg_value(r.sel));
                OP_CHKV: read_check(r.sel, r.exp);
                default: begin
                    for (int i = 0; i < 9; i++) begin
                        c = 4'(i);
                        read_check(c, mreg[c]);
                    end
                end
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: tb/stk_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions for the stack engine top level
// attached to every stk_top instance by the bind below
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_assert (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic ram_we
);

    // done lasts exactly one cycle
    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held high for more than one cycle");

    // memory writes only happen inside a transfer
    we_in_busy: assert property (@(posedge clk) disable iff (rst) ram_we |-> busy)
        else $error("stack RAM written while busy is low");

    // clean outputs right after reset
    reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !busy && !done && !ram_we)
        else $error("busy, done or RAM write high after reset");

endmodule

bind stk_top stk_assert u_stk_assert (
    .clk    (clk),
    .rst    (rst),
    .busy   (busy),
    .done   (done),
    .ram_we (ram_we)
);

// File: design/stk_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file with byte-serial push/pull on the u or s stack
// host loads and reads registers, starts transfers by strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_top #(
    parameter int STK_AW = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  stk_pkg::reg_sel_t  load_sel,
    input  stk_pkg::word_t     load_data,
    input  logic               push,
    input  logic               pull,
    input  logic               use_u,
    input  stk_pkg::reg_mask_t mask,
    input  stk_pkg::reg_sel_t  rd_sel,
    output stk_pkg::word_t     rd_data,
    output logic               busy,
    output logic               done
);

    logic               xfer_en;
    logic               dir_push;
    logic               ctr_load;
    logic               empty;
    logic               last_byte;
    logic               hilon;
    logic               ram_we;
    stk_pkg::reg_mask_t cur_bit;
    stk_pkg::byte_t     byte_cnt;
    stk_pkg::word_t     stk_ptr;
    stk_pkg::byte_t     psh_byte;
    stk_pkg::byte_t     rd_byte;

    // memory is written only on push cycles
    assign ram_we = xfer_en & dir_push;

    stk_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pull      (pull),
        .empty     (empty),
        .last_byte (last_byte),
        .ctr_load  (ctr_load),
        .xfer_en   (xfer_en),
        .dir_push  (dir_push),
        .busy      (busy),
        .done      (done)
    );

    stk_mask_ctr u_mask_ctr (
        .clk       (clk),
        .rst       (rst),
        .ctr_load  (ctr_load),
        .mask      (mask),
        .dir_push  (dir_push),
        .step      (xfer_en),
        .cur_bit   (cur_bit),
        .hilon     (hilon),
        .last_byte (last_byte),
        .empty     (empty),
        .byte_cnt  (byte_cnt)
    );

    stk_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_sel  (load_sel),
        .load_data (load_data),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .xfer_en   (xfer_en),
        .dir_push  (dir_push),
        .use_u     (use_u),
        .cur_bit   (cur_bit),
        .hilon     (hilon),
        .rd_byte   (rd_byte),
        .psh_byte  (psh_byte),
        .stk_ptr   (stk_ptr)
    );

    stk_ram #(
        .STK_AW (STK_AW)
    ) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (stk_ptr),
        .wdata (psh_byte),
        .rdata (rd_byte)
    );

endmodule

// File: design/stk_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file with host load/readback and the byte paths
// used by push and pull transfers, plus u/s pointer update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  stk_pkg::reg_sel_t  load_sel,
    input  stk_pkg::word_t     load_data,
    input  stk_pkg::reg_sel_t  rd_sel,
    output stk_pkg::word_t     rd_data,
    input  logic               xfer_en,
    input  logic               dir_push,
    input  logic               use_u,
    input  stk_pkg::reg_mask_t cur_bit,
    input  logic               hilon,
    input  stk_pkg::byte_t     rd_byte,
    output stk_pkg::byte_t     psh_byte,
    output stk_pkg::word_t     stk_ptr
);

    stk_pkg::byte_t a;
    stk_pkg::byte_t b;
    stk_pkg::byte_t dp;
    stk_pkg::byte_t cc;
    stk_pkg::word_t x;
    stk_pkg::word_t y;
    stk_pkg::word_t u;
    stk_pkg::word_t s;
    stk_pkg::word_t pc;
    logic           use_u_q;
    stk_pkg::word_t act_ptr;
    stk_pkg::word_t oth_ptr;
    stk_pkg::word_t nx_u;
    stk_pkg::word_t nx_s;

    function automatic stk_pkg::byte_t pick(stk_pkg::word_t w, logic hi);
        return hi ? w[15:8] : w[7:0];
    endfunction

    function automatic stk_pkg::word_t put(stk_pkg::word_t w, logic hi, stk_pkg::byte_t v);
        stk_pkg::word_t r;
        r = w;
        if (hi) begin
            r[15:8] = v;
        end else begin
            r[7:0] = v;
        end
        return r;
    endfunction

    // stack choice is frozen for the length of a transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            use_u_q <= 1'b0;
        end else if (!xfer_en) begin
            use_u_q <= use_u;
        end
    end

    assign act_ptr = use_u_q ? u : s;
    assign oth_ptr = use_u_q ? s : u;

    // push writes at the pre-decremented pointer
    assign stk_ptr = dir_push ? act_ptr - 16'd1 : act_ptr;

    always_comb begin
        case (cur_bit)
            8'h01:   psh_byte = cc;
            8'h02:   psh_byte = a;
            8'h04:   psh_byte = b;
            8'h08:   psh_byte = dp;
            8'h10:   psh_byte = pick(x, hilon);
            8'h20:   psh_byte = pick(y, hilon);
            8'h40:   psh_byte = pick(oth_ptr, hilon);
            8'h80:   psh_byte = pick(pc, hilon);
            default: psh_byte = '0;
        endcase
    end

    always_comb begin
        nx_u = u;
        nx_s = s;
        if (xfer_en) begin
            // active stack moves by one byte
            if (use_u_q) begin
                nx_u = dir_push ? u - 16'd1 : u + 16'd1;
            end else begin
                nx_s = dir_push ? s - 16'd1 : s + 16'd1;
            end
            // other stack pointer pulled from memory
            if (!dir_push && cur_bit[6]) begin
                if (use_u_q) begin
                    nx_s = put(s, hilon, rd_byte);
                end else begin
                    nx_u = put(u, hilon, rd_byte);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            dp <= '0;
            cc <= '0;
            x  <= '0;
            y  <= '0;
            u  <= '0;
            s  <= '0;
            pc <= '0;
        end else if (xfer_en) begin
            u <= nx_u;
            s <= nx_s;
            if (!dir_push) begin
                if (cur_bit[0]) cc <= rd_byte;
                if (cur_bit[1]) a  <= rd_byte;
                if (cur_bit[2]) b  <= rd_byte;
                if (cur_bit[3]) dp <= rd_byte;
                if (cur_bit[4]) x  <= put(x, hilon, rd_byte);
                if (cur_bit[5]) y  <= put(y, hilon, rd_byte);
                if (cur_bit[7]) pc <= put(pc, hilon, rd_byte);
            end
        end else if (load) begin
            case (load_sel)
                stk_pkg::REG_A:  a  <= load_data[7:0];
                stk_pkg::REG_B:  b  <= load_data[7:0];
                stk_pkg::REG_DP: dp <= load_data[7:0];
                stk_pkg::REG_CC: cc <= load_data[7:0];
                stk_pkg::REG_X:  x  <= load_data;
                stk_pkg::REG_Y:  y  <= load_data;
                stk_pkg::REG_U:  u  <= load_data;
                stk_pkg::REG_S:  s  <= load_data;
                stk_pkg::REG_PC: pc <= load_data;
                default: ;
            endcase
        end
    end

    // byte registers read back zero-extended
    always_comb begin
        case (rd_sel)
            stk_pkg::REG_A:  rd_data = {8'h00, a};
            stk_pkg::REG_B:  rd_data = {8'h00, b};
            stk_pkg::REG_DP: rd_data = {8'h00, dp};
            stk_pkg::REG_CC: rd_data = {8'h00, cc};
            stk_pkg::REG_X:  rd_data = x;
            stk_pkg::REG_Y:  rd_data = y;
            stk_pkg::REG_U:  rd_data = u;
            stk_pkg::REG_S:  rd_data = s;
            stk_pkg::REG_PC: rd_data = pc;
            default:         rd_data = '0;
        endcase
    end

endmodule

// File: design/stk_mask_ctr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// remaining mask and byte phase for one push or pull transfer
// picks the register served next and counts bytes moved
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_mask_ctr (
    input  logic               clk,
    input  logic               rst,
    input  logic               ctr_load,
    input  stk_pkg::reg_mask_t mask,
    input  logic               dir_push,
    input  logic               step,
    output stk_pkg::reg_mask_t cur_bit,
    output logic               hilon,
    output logic               last_byte,
    output logic               empty,
    output stk_pkg::byte_t     byte_cnt
);

    stk_pkg::reg_mask_t rem;
    logic               second;
    logic               is_word;
    logic               reg_end;

    function automatic stk_pkg::reg_mask_t high_bit(stk_pkg::reg_mask_t m);
        stk_pkg::reg_mask_t r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) begin
                r    = '0;
                r[i] = 1'b1;
            end
        end
        return r;
    endfunction

    // push walks down from pc, pull walks up from cc
    assign cur_bit = dir_push ? high_bit(rem) : (rem & (~rem + 8'd1));

    // bits 4..7 are the 16-bit registers
    assign is_word = |cur_bit[7:4];

    // push stores low then high, pull takes high then low
    assign hilon   = dir_push ? second : ~second;
    assign reg_end = !is_word || second;

    assign last_byte = reg_end && ((rem & ~cur_bit) == '0);

    // while loading, look at the incoming mask
    assign empty = ctr_load ? (mask == '0) : (rem == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem      <= '0;
            second   <= 1'b0;
            byte_cnt <= '0;
        end else if (ctr_load) begin
            rem      <= mask;
            second   <= 1'b0;
            byte_cnt <= '0;
        end else if (step) begin
            byte_cnt <= byte_cnt + 8'd1;
            if (reg_end) begin
                rem    <= rem & ~cur_bit;
                second <= 1'b0;
            end else begin
                second <= 1'b1;
            end
        end
    end

endmodule

// File: design/stk_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transfer FSM, starts on a push or pull strobe in IDLE,
// moves one byte per cycle and ends with a one-cycle done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_seq (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pull,
    input  logic empty,
    input  logic last_byte,
    output logic ctr_load,
    output logic xfer_en,
    output logic dir_push,
    output logic busy,
    output logic done
);

    stk_pkg::seq_state_t state;
    stk_pkg::seq_state_t nx_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= stk_pkg::IDLE;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        ctr_load = 1'b0;
        case (state)
            stk_pkg::IDLE: begin
                // push has priority over pull
                if (push || pull) begin
                    ctr_load = 1'b1;
                    if (empty) begin
                        nx_state = stk_pkg::DONE;
                    end else if (push) begin
                        nx_state = stk_pkg::PUSH;
                    end else begin
                        nx_state = stk_pkg::PULL;
                    end
                end
            end
            stk_pkg::PUSH,
            stk_pkg::PULL: begin
                if (last_byte) begin
                    nx_state = stk_pkg::DONE;
                end
            end
            stk_pkg::DONE: begin
                nx_state = stk_pkg::IDLE;
            end
            default: begin
                nx_state = stk_pkg::IDLE;
            end
        endcase
    end

    assign xfer_en  = (state == stk_pkg::PUSH) || (state == stk_pkg::PULL);
    assign dir_push = (state == stk_pkg::PUSH);
    assign busy     = xfer_en;
    assign done     = (state == stk_pkg::DONE);

endmodule

// File: design/stk_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-wide stack memory, clocked write and async read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stk_ram #(
    parameter int STK_AW = 8
) (
    input  logic           clk,
    input  logic           we,
    input  stk_pkg::word_t addr,
    input  stk_pkg::byte_t wdata,
    output stk_pkg::byte_t rdata
);

    stk_pkg::byte_t mem [0:(1 << STK_AW) - 1];

    // pointer wraps within the memory range
    logic [STK_AW-1:0] idx;

    assign idx = addr[STK_AW-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

// File: design/stk_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and codes for the register file and stack engine
// referenced with scoped names from the design and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stk_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // push/pull mask, bit 0 cc up to bit 7 pc
    typedef logic [7:0]  reg_mask_t;

    // register code for load and readback
    typedef logic [3:0]  reg_sel_t;

    localparam reg_sel_t REG_A  = 4'd0;
    localparam reg_sel_t REG_B  = 4'd1;
    localparam reg_sel_t REG_DP = 4'd2;
    localparam reg_sel_t REG_CC = 4'd3;
    localparam reg_sel_t REG_X  = 4'd4;
    localparam reg_sel_t REG_Y  = 4'd5;
    localparam reg_sel_t REG_U  = 4'd6;
    localparam reg_sel_t REG_S  = 4'd7;
    localparam reg_sel_t REG_PC = 4'd8;

    // condition code bit positions
    localparam int CC_E = 7;
    localparam int CC_F = 6;
    localparam int CC_I = 4;

    // transfer sequencer states
    typedef enum logic [1:0] {
        IDLE,
        PUSH,
        PULL,
        DONE
    } seq_state_t;

endpackage
